// File: list.f
+incdir+.
rp_pkg.sv
adc_front.sv
dac_back.sv
exp_trig_ctrl.sv
analog_top.sv
tb_analog_top.sv

// File: tb_model.svh
// Reference functions for ADC conversion, DAC saturation and offset code, pin and trigger routing
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Negative slope raw sample to two's complement, low 15 bits flipped
function automatic logic [ADC_DW-1:0] model_adc_conv(input logic [ADC_DW-1:0] raw);
  return raw ^ {1'b0, {(ADC_DW-1){1'b1}}};
endfunction

// Loopback value, zeros above the 14 bits
function automatic logic [ADC_DW-1:0] model_loop_ext(input logic [DAC_DW-1:0] val);
  logic [ADC_DW-1:0] ext;
  ext = '0;
  ext[DAC_DW-1:0] = val;
  return ext;
endfunction

// Integer sum, then clamp into the 14-bit signed range
function automatic logic [DAC_DW-1:0] model_sat(input logic signed [DAC_DW-1:0] a,
                                                input logic signed [DAC_DW-1:0] b);
  int sum;
  int lim;
  lim = 1 << (DAC_DW - 1);
  sum = int'(a) + int'(b);
  if (sum > lim - 1)
    sum = lim - 1;      // Positive full scale
  else if (sum < -lim)
    sum = -lim;         // Negative full scale
  return sum[DAC_DW-1:0];
endfunction

// Sign kept, lower 13 bits flipped
function automatic logic [DAC_DW-1:0] model_offset_code(input logic [DAC_DW-1:0] val);
  return val ^ {1'b0, {(DAC_DW-1){1'b1}}};
endfunction

function automatic logic model_trig_out(input logic [2:0] mode, input logic scope,
                                        input logic asg);
  return mode[DMODE_ASG_SRC] ? asg : scope;
endfunction

// N side pin values, alternate functions on top of housekeeping
function automatic logic [EXP_W-1:0] model_exp_n(input logic [2:0] mode, input logic trig,
    input logic can_on, input logic can0, input logic can1, input logic [EXP_W-1:0] hk_dat);
  logic [EXP_W-1:0] pins;
  pins = hk_dat;
  if (mode[DMODE_TRIG_PIN])
    pins[0] = trig;
  if (can_on) begin
    pins[CAN0_PIN] = can0;
    pins[CAN1_PIN] = can1;
  end
  return pins;
endfunction

// N side enables, alternate pins forced to drive
function automatic logic [EXP_W-1:0] model_exp_n_oe(input logic [2:0] mode,
    input logic can_on, input logic [EXP_W-1:0] hk_dir);
  logic [EXP_W-1:0] oe;
  oe = hk_dir;
  if (mode[DMODE_TRIG_PIN])
    oe[0] = 1'b1;
  if (can_on) begin
    oe[CAN0_PIN] = 1'b1;
    oe[CAN1_PIN] = 1'b1;
  end
  return oe;
endfunction

`endif

// File: tb_analog_top.sv
// Testbench for analog_top with seeded random stimulus, reference model checks and report
`timescale 1ns/1ps
`default_nettype none

module tb_analog_top;

  import rp_pkg::*;

  localparam int unsigned EXP_W      = 11;
  localparam int unsigned RST_CYCLES = 8;
  localparam int unsigned RUN_CYCLES = 400;
  localparam int unsigned WAIT_LIMIT = 16;  // Cycles before a wait gives up

  logic                adc_clk, rst_n_i, loop_en_i;
  logic [ADC_DW-1:0]   adc_a_raw_i, adc_b_raw_i;
  adc_sample_t         adc_a_o, adc_b_o;
  dac_sample_t         asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  dac_code_t           dac_a_o, dac_b_o;
  logic [EXP_W-1:0]    exp_p_i, exp_n_i, exp_p_o, exp_n_o, exp_p_oe_o, exp_n_oe_o;
  logic [EXP_W-1:0]    hk_p_dat_i, hk_n_dat_i, hk_p_dir_i, hk_n_dir_i;
  logic [2:0]          daisy_mode_i;
  logic [DAISY_DW-1:0] daisy_rx_dat_i, daisy_tx_dat_o;
  logic                daisy_rx_rdy_i, daisy_tx_dv_o, scope_trig_i, asg_trig_i, trig_ext_o;
  logic                can_on_i, can0_tx_i, can1_tx_i, can0_rx_o, can1_rx_o;

  logic [ADC_DW-1:0]   want_adc_a, want_adc_b;  // Registered outputs due next cycle
  logic [DAC_DW-1:0]   want_dac_a, want_dac_b;
  int unsigned         reg_errors, comb_errors, checks;
  bit                  outs_known;

  `include "tb_model.svh"

  analog_top #(.EXP_W(EXP_W)) analog_top_i (.*);

  always #20 adc_clk = ~adc_clk;  // 40 ns period

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic report_error(input string what, input logic [31:0] got,
                              input logic [31:0] want, input bit comb);
    if (comb)
      comb_errors++;
    else
      reg_errors++;
    $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
  endtask

  // Near full scale half of the time so sums overflow
  function automatic dac_sample_t rand_dac_sample();
    logic [DAC_DW-1:0] s;
    int unsigned       pick;
    pick = $urandom % 4;
    s    = DAC_DW'($urandom);
    if (pick == 0)
      s = {1'b0, {(DAC_DW-1){1'b1}}} - DAC_DW'($urandom % 256);
    else if (pick == 1)
      s = {1'b1, {(DAC_DW-1){1'b0}}} + DAC_DW'($urandom % 256);
    return s;
  endfunction

  task automatic clear_inputs();
    {loop_en_i, adc_a_raw_i, adc_b_raw_i, asg_a_i, asg_b_i, pid_a_i, pid_b_i} = '0;
    {exp_p_i, exp_n_i, hk_p_dat_i, hk_n_dat_i, hk_p_dir_i, hk_n_dir_i} = '0;
    {daisy_mode_i, daisy_rx_dat_i, daisy_rx_rdy_i, scope_trig_i, asg_trig_i} = '0;
    {can_on_i, can0_tx_i, can1_tx_i} = '0;
  endtask

  task automatic drive_random();
    adc_a_raw_i    = ADC_DW'($urandom);
    adc_b_raw_i    = ADC_DW'($urandom);
    loop_en_i      = $urandom;
    asg_a_i        = rand_dac_sample();
    asg_b_i        = rand_dac_sample();
    pid_a_i        = rand_dac_sample();
    pid_b_i        = rand_dac_sample();
    exp_p_i        = EXP_W'($urandom);
    exp_n_i        = EXP_W'($urandom);
    hk_p_dat_i     = EXP_W'($urandom);
    hk_n_dat_i     = EXP_W'($urandom);
    hk_p_dir_i     = EXP_W'($urandom);
    hk_n_dir_i     = EXP_W'($urandom);
    daisy_mode_i   = 3'($urandom);
    daisy_rx_dat_i = ($urandom % 2) ? DAISY_DW'($urandom) : '0;  // Idle rx half the time
    daisy_rx_rdy_i = $urandom;
    scope_trig_i   = $urandom;
    asg_trig_i     = $urandom;
    {can_on_i, can0_tx_i, can1_tx_i} = 3'($urandom);
    // Values the next rising edge should capture
    want_dac_a = model_offset_code(model_sat(asg_a_i, pid_a_i));
    want_dac_b = model_offset_code(model_sat(asg_b_i, pid_b_i));
    want_adc_a = loop_en_i ? model_loop_ext(model_sat(asg_a_i, pid_a_i))
                           : model_adc_conv(adc_a_raw_i);
    want_adc_b = loop_en_i ? model_loop_ext(model_sat(asg_b_i, pid_b_i))
                           : model_adc_conv(adc_b_raw_i);
  endtask

  // Leave X behind after reset, bounded
  task automatic wait_outputs_known(output bit ok);
    int unsigned waited;
    waited = 0;
    while ($isunknown({adc_a_o, adc_b_o, dac_a_o, dac_b_o}) && waited < WAIT_LIMIT) begin
      @(negedge adc_clk);
      waited++;
    end
    ok = !$isunknown({adc_a_o, adc_b_o, dac_a_o, dac_b_o});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_regs(input logic [ADC_DW-1:0] adc_a, input logic [ADC_DW-1:0] adc_b,
                            input logic [DAC_DW-1:0] dac_a, input logic [DAC_DW-1:0] dac_b);
    checks += 4;
    assert (adc_a_o === adc_a) else report_error("adc_a_o", unsigned'(adc_a_o), adc_a, 0);
    assert (adc_b_o === adc_b) else report_error("adc_b_o", unsigned'(adc_b_o), adc_b, 0);
    assert (dac_a_o === dac_a) else report_error("dac_a_o", dac_a_o, dac_a, 0);
    assert (dac_b_o === dac_b) else report_error("dac_b_o", dac_b_o, dac_b, 0);
  endtask

  task automatic check_comb();
    logic                trig;
    logic                want_ext;
    logic                want_dv;
    logic                want_can0;
    logic                want_can1;
    logic [DAISY_DW-1:0] want_dat;
    logic [EXP_W-1:0]    want_n;
    logic [EXP_W-1:0]    want_oe;
    trig     = model_trig_out(daisy_mode_i, scope_trig_i, asg_trig_i);
    want_ext = exp_p_i[0];
    if (daisy_mode_i[DMODE_SYNC] && daisy_rx_dat_i != '0)
      want_ext = 1'b0;  // Chain busy
    if (daisy_mode_i[DMODE_SYNC]) begin
      want_dat = trig ? '1 : '0;  // Trigger copied into every bit
      want_dv  = 1'b0;
    end else begin
      want_dat = DAISY_TEST_WORD;
      want_dv  = daisy_rx_rdy_i;
    end
    want_can0 = 1'b0;
    want_can1 = 1'b0;
    if (can_on_i) begin
      want_can0 = exp_p_i[CAN0_PIN];  // Receive seen only with CAN on
      want_can1 = exp_p_i[CAN1_PIN];
    end
    want_n   = model_exp_n(daisy_mode_i, trig, can_on_i, can0_tx_i, can1_tx_i, hk_n_dat_i);
    want_oe  = model_exp_n_oe(daisy_mode_i, can_on_i, hk_n_dir_i);
    checks += 9;
    assert (exp_p_o === hk_p_dat_i) else report_error("exp_p_o", exp_p_o, hk_p_dat_i, 1);
    assert (exp_p_oe_o === hk_p_dir_i) else report_error("exp_p_oe_o", exp_p_oe_o, hk_p_dir_i, 1);
    assert (exp_n_o === want_n) else report_error("exp_n_o", exp_n_o, want_n, 1);
    assert (exp_n_oe_o === want_oe) else report_error("exp_n_oe_o", exp_n_oe_o, want_oe, 1);
    assert (can0_rx_o === want_can0)
      else report_error("can0_rx_o", can0_rx_o, want_can0, 1);
    assert (can1_rx_o === want_can1)
      else report_error("can1_rx_o", can1_rx_o, want_can1, 1);
    assert (trig_ext_o === want_ext) else report_error("trig_ext_o", trig_ext_o, want_ext, 1);
    assert (daisy_tx_dat_o === want_dat)
      else report_error("daisy_tx_dat_o", daisy_tx_dat_o, want_dat, 1);
    assert (daisy_tx_dv_o === want_dv)
      else report_error("daisy_tx_dv_o", daisy_tx_dv_o, want_dv, 1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h8fd6c89e));
    reg_errors  = 0;
    comb_errors = 0;
    checks      = 0;
    adc_clk     = 1'b0;
    rst_n_i     = 1'b0;
    clear_inputs();
    repeat (RST_CYCLES) @(negedge adc_clk);
    wait_outputs_known(outs_known);
    if (!outs_known) begin
      $display("ADC and DAC outputs stayed unknown after reset was applied");
      $display("TEST FAILED");
      $finish;
    end else begin
      check_regs('0, '0, 14'h1FFF, 14'h1FFF);  // Mid scale code, zero samples
      rst_n_i = 1'b1;
      drive_random();
      repeat (RUN_CYCLES) begin
        #5 check_comb();
        @(negedge adc_clk);
        check_regs(want_adc_a, want_adc_b, want_dac_a, want_dac_b);
        drive_random();
      end
      #5 check_comb();
      $display("checks %0d, registered errors %0d, combinational errors %0d",
               checks, reg_errors, comb_errors);
      if (reg_errors == 0 && comb_errors == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule : tb_analog_top

`default_nettype wire

// File: analog_top.sv
// Top level joining ADC front end, DAC back end and trigger and pin routing
`timescale 1ns/1ps
`default_nettype none

module analog_top #(
  parameter int unsigned EXP_W = 11  // Expansion connector width
) (
  input  wire logic                        adc_clk,
  input  wire logic                        rst_n_i,       // Sync reset, active low
  // ADC
  input  wire logic [rp_pkg::ADC_DW-1:0]   adc_a_raw_i,
  input  wire logic [rp_pkg::ADC_DW-1:0]   adc_b_raw_i,
  input  wire logic                        loop_en_i,     // Digital loopback
  output rp_pkg::adc_sample_t              adc_a_o,
  output rp_pkg::adc_sample_t              adc_b_o,
  // DAC
  input  wire rp_pkg::dac_sample_t         asg_a_i,
  input  wire rp_pkg::dac_sample_t         asg_b_i,
  input  wire rp_pkg::dac_sample_t         pid_a_i,
  input  wire rp_pkg::dac_sample_t         pid_b_i,
  output rp_pkg::dac_code_t                dac_a_o,
  output rp_pkg::dac_code_t                dac_b_o,
  // Expansion connector
  input  wire logic [EXP_W-1:0]            exp_p_i,
  input  wire logic [EXP_W-1:0]            exp_n_i,
  output logic [EXP_W-1:0]                 exp_p_o,
  output logic [EXP_W-1:0]                 exp_n_o,
  output logic [EXP_W-1:0]                 exp_p_oe_o,
  output logic [EXP_W-1:0]                 exp_n_oe_o,
  input  wire logic [EXP_W-1:0]            hk_p_dat_i,
  input  wire logic [EXP_W-1:0]            hk_n_dat_i,
  input  wire logic [EXP_W-1:0]            hk_p_dir_i,
  input  wire logic [EXP_W-1:0]            hk_n_dir_i,
  // Daisy chain
  input  wire logic [2:0]                  daisy_mode_i,
  input  wire logic [rp_pkg::DAISY_DW-1:0] daisy_rx_dat_i,
  input  wire logic                        daisy_rx_rdy_i,
  output logic [rp_pkg::DAISY_DW-1:0]      daisy_tx_dat_o,
  output logic                             daisy_tx_dv_o,
  // Triggers
  input  wire logic                        scope_trig_i,
  input  wire logic                        asg_trig_i,
  output logic                             trig_ext_o,
  // CAN
  input  wire logic                        can_on_i,
  input  wire logic                        can0_tx_i,
  input  wire logic                        can1_tx_i,
  output logic                             can0_rx_o,
  output logic                             can1_rx_o
);

  import rp_pkg::*;

  dac_sample_t loop_a;  // Saturated DAC value, channel A
  dac_sample_t loop_b;

  //////////////////////////////////////////////////////////////////////
  // Analog data path
  //////////////////////////////////////////////////////////////////////

  adc_front adc_front_i (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_raw_i (adc_a_raw_i),
    .adc_b_raw_i (adc_b_raw_i),
    .loop_en_i   (loop_en_i),
    .loop_a_i    (loop_a),       // From DAC sum
    .loop_b_i    (loop_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o)
  );

  dac_back dac_back_i (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .asg_a_i  (asg_a_i),
    .asg_b_i  (asg_b_i),
    .pid_a_i  (pid_a_i),
    .pid_b_i  (pid_b_i),
    .loop_a_o (loop_a),
    .loop_b_o (loop_b),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Triggers, daisy word and expansion pins
  //////////////////////////////////////////////////////////////////////

  exp_trig_ctrl #(
    .EXP_W (EXP_W)
  ) exp_trig_ctrl_i (
    .exp_p_i        (exp_p_i),
    .exp_n_i        (exp_n_i),
    .exp_p_o        (exp_p_o),
    .exp_n_o        (exp_n_o),
    .exp_p_oe_o     (exp_p_oe_o),
    .exp_n_oe_o     (exp_n_oe_o),
    .hk_p_dat_i     (hk_p_dat_i),
    .hk_n_dat_i     (hk_n_dat_i),
    .hk_p_dir_i     (hk_p_dir_i),
    .hk_n_dir_i     (hk_n_dir_i),
    .daisy_mode_i   (daisy_mode_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .daisy_tx_dat_o (daisy_tx_dat_o),
    .daisy_tx_dv_o  (daisy_tx_dv_o),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .trig_ext_o     (trig_ext_o),
    .can_on_i       (can_on_i),
    .can0_tx_i      (can0_tx_i),
    .can1_tx_i      (can1_tx_i),
    .can0_rx_o      (can0_rx_o),
    .can1_rx_o      (can1_rx_o)
  );

endmodule : analog_top

`default_nettype wire

// File: exp_trig_ctrl.sv
// Trigger routing, daisy transmit word select and expansion pin alternate functions
`timescale 1ns/1ps
`default_nettype none

module exp_trig_ctrl #(
  parameter int unsigned EXP_W = 11  // Expansion width, at least 8
) (
  // Expansion pads, split into in, out and enable
  input  wire logic [EXP_W-1:0]            exp_p_i,
  input  wire logic [EXP_W-1:0]            exp_n_i,
  output logic [EXP_W-1:0]                 exp_p_o,
  output logic [EXP_W-1:0]                 exp_n_o,
  output logic [EXP_W-1:0]                 exp_p_oe_o,
  output logic [EXP_W-1:0]                 exp_n_oe_o,
  // Housekeeping GPIO values and directions
  input  wire logic [EXP_W-1:0]            hk_p_dat_i,
  input  wire logic [EXP_W-1:0]            hk_n_dat_i,
  input  wire logic [EXP_W-1:0]            hk_p_dir_i,   // 1 = output
  input  wire logic [EXP_W-1:0]            hk_n_dir_i,
  // Daisy chain
  input  wire logic [2:0]                  daisy_mode_i,
  input  wire logic [rp_pkg::DAISY_DW-1:0] daisy_rx_dat_i,
  input  wire logic                        daisy_rx_rdy_i,
  output logic [rp_pkg::DAISY_DW-1:0]      daisy_tx_dat_o,
  output logic                             daisy_tx_dv_o,
  // Triggers
  input  wire logic                        scope_trig_i,
  input  wire logic                        asg_trig_i,
  output logic                             trig_ext_o,
  // CAN
  input  wire logic                        can_on_i,
  input  wire logic                        can0_tx_i,
  input  wire logic                        can1_tx_i,
  output logic                             can0_rx_o,
  output logic                             can1_rx_o
);

  import rp_pkg::*;

  logic             sync_mode;   // Daisy sync active
  logic             daisy_trig;  // Anything seen on the daisy rx
  logic             trig_out;    // Selected output trigger
  logic [EXP_W-1:0] n_alt;       // Pin taken over by alternate function
  logic [EXP_W-1:0] n_alt_dat;   // Alternate function value

  //////////////////////////////////////////////////////////////////////
  // Triggers and daisy word
  //////////////////////////////////////////////////////////////////////

  assign sync_mode  = daisy_mode_i[DMODE_SYNC];
  assign daisy_trig = |daisy_rx_dat_i;

  // External trigger pin, blocked while the chain is busy
  assign trig_ext_o = exp_p_i[0] & ~(sync_mode & daisy_trig);

  assign trig_out = daisy_mode_i[DMODE_ASG_SRC] ? asg_trig_i : scope_trig_i;

  // Sync mode repeats the trigger, otherwise send the test pattern
  assign daisy_tx_dat_o = sync_mode ? {DAISY_DW{trig_out}} : DAISY_TEST_WORD;
  assign daisy_tx_dv_o  = sync_mode ? 1'b0 : daisy_rx_rdy_i;

  //////////////////////////////////////////////////////////////////////
  // Expansion pins
  //////////////////////////////////////////////////////////////////////

  // Alternate function map of the n side
  always_comb begin
    n_alt               = '0;
    n_alt_dat           = '0;
    n_alt[0]            = daisy_mode_i[DMODE_TRIG_PIN];  // Trigger out
    n_alt_dat[0]        = trig_out;
    n_alt[CAN0_PIN]     = can_on_i;
    n_alt_dat[CAN0_PIN] = can0_tx_i;
    n_alt[CAN1_PIN]     = can_on_i;
    n_alt_dat[CAN1_PIN] = can1_tx_i;
  end

  // Alternate pins always drive, others follow housekeeping
  assign exp_n_o    = (n_alt & n_alt_dat) | (~n_alt & hk_n_dat_i);
  assign exp_n_oe_o = n_alt | hk_n_dir_i;

  // P side has no alternate outputs
  assign exp_p_o    = hk_p_dat_i;
  assign exp_p_oe_o = hk_p_dir_i;

  // CAN receive sits on the p side
  assign can0_rx_o = can_on_i & exp_p_i[CAN0_PIN];
  assign can1_rx_o = can_on_i & exp_p_i[CAN1_PIN];

endmodule : exp_trig_ctrl

`default_nettype wire

// File: dac_back.sv
// DAC path with generator plus controller sum, saturation and offset code register
`timescale 1ns/1ps
`default_nettype none

module dac_back (
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,   // Sync reset, active low
  // Generator samples
  input  wire rp_pkg::dac_sample_t  asg_a_i,
  input  wire rp_pkg::dac_sample_t  asg_b_i,
  // Controller samples
  input  wire rp_pkg::dac_sample_t  pid_a_i,
  input  wire rp_pkg::dac_sample_t  pid_b_i,
  // Saturated values, combinational, to ADC loopback
  output rp_pkg::dac_sample_t       loop_a_o,
  output rp_pkg::dac_sample_t       loop_b_o,
  // Offset codes to the converter
  output rp_pkg::dac_code_t         dac_a_o,
  output rp_pkg::dac_code_t         dac_b_o
);

  import rp_pkg::*;

  // Code of a zero sample, held after reset
  localparam dac_code_t CODE_ZERO = {1'b0, {(DAC_DW-1){1'b1}}};

  // Clamp a 15-bit sum into 14 bits
  function automatic dac_sample_t dac_sat(input logic signed [DAC_DW:0] sum);
    if (sum[DAC_DW] != sum[DAC_DW-1])  // Overflow, top two bits differ
      return {sum[DAC_DW], {(DAC_DW-1){~sum[DAC_DW]}}};
    return sum[DAC_DW-1:0];
  endfunction

  // Signed to negative-slope offset code
  function automatic dac_code_t dac_code(input dac_sample_t val);
    return {val[DAC_DW-1], ~val[DAC_DW-2:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Sum and saturation
  //////////////////////////////////////////////////////////////////////

  logic signed [DAC_DW:0] sum_a;  // One bit of headroom
  logic signed [DAC_DW:0] sum_b;

  assign sum_a = asg_a_i + pid_a_i;  // Operands sign extended
  assign sum_b = asg_b_i + pid_b_i;

  assign loop_a_o = dac_sat(sum_a);
  assign loop_b_o = dac_sat(sum_b);

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_a_o <= CODE_ZERO;  // Mid scale
      dac_b_o <= CODE_ZERO;
    end else begin
      dac_a_o <= dac_code(loop_a_o);
      dac_b_o <= dac_code(loop_b_o);
    end
  end

endmodule : dac_back

`default_nettype wire

// File: adc_front.sv
// ADC sample conversion to two's complement with digital loopback register
`timescale 1ns/1ps
`default_nettype none

module adc_front (
  input  wire logic                        adc_clk,
  input  wire logic                        rst_n_i,     // Sync reset, active low
  // Raw converter samples, negative slope
  input  wire logic [rp_pkg::ADC_DW-1:0]   adc_a_raw_i,
  input  wire logic [rp_pkg::ADC_DW-1:0]   adc_b_raw_i,
  // Loopback from the DAC path
  input  wire logic                        loop_en_i,
  input  wire rp_pkg::dac_sample_t         loop_a_i,
  input  wire rp_pkg::dac_sample_t         loop_b_i,
  // Converted samples
  output rp_pkg::adc_sample_t              adc_a_o,
  output rp_pkg::adc_sample_t              adc_b_o
);

  import rp_pkg::*;

  // Keep MSB, flip the rest
  function automatic adc_sample_t adc_conv(input logic [ADC_DW-1:0] raw);
    return adc_sample_t'({raw[ADC_DW-1], ~raw[ADC_DW-2:0]});
  endfunction

  // Zero extended, not sign extended, as the board has always done
  function automatic adc_sample_t loop_ext(input dac_sample_t val);
    return adc_sample_t'({{(ADC_DW-DAC_DW){1'b0}}, val});
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Input register, one clock of latency
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else if (loop_en_i) begin
      adc_a_o <= loop_ext(loop_a_i);  // DAC value fed back
      adc_b_o <= loop_ext(loop_b_i);
    end else begin
      adc_a_o <= adc_conv(adc_a_raw_i);
      adc_b_o <= adc_conv(adc_b_raw_i);
    end
  end

endmodule : adc_front

`default_nettype wire

// File: rp_pkg.sv
// Shared widths, sample types, daisy test word and mode bit and pin positions
`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sample widths and types
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_DW = 16;  // ADC sample width
  localparam int unsigned DAC_DW = 14;  // DAC sample width

  // Two's complement samples after conversion
  typedef logic signed [ADC_DW-1:0] adc_sample_t;
  typedef logic signed [DAC_DW-1:0] dac_sample_t;

  // Negative-slope offset code as the converter wants it
  typedef logic [DAC_DW-1:0] dac_code_t;

  //////////////////////////////////////////////////////////////////////
  // Daisy chain
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DAISY_DW = 16;  // Parallel word width

  // Fixed pattern sent when not in sync mode
  localparam logic [DAISY_DW-1:0] DAISY_TEST_WORD = 16'h1234;

  // Bit positions inside the 3-bit daisy mode word
  localparam int unsigned DMODE_SYNC     = 0;  // Sync active, rx masks ext trigger
  localparam int unsigned DMODE_TRIG_PIN = 1;  // Trigger out on exp_n[0]
  localparam int unsigned DMODE_ASG_SRC  = 2;  // Generator drives trigger out

  //////////////////////////////////////////////////////////////////////
  // Expansion connector alternate pins
  //////////////////////////////////////////////////////////////////////

  // CAN transmit on the n side, receive on the p side
  localparam int unsigned CAN0_PIN = 7;
  localparam int unsigned CAN1_PIN = 6;

endpackage : rp_pkg

`default_nettype wire
